/* tb.f */
tcb_pkg.sv
tcb_map_decoder.sv
tcb_lib_demultiplexer.sv
tcb_sram.sv
tcb_fifo_port.sv
tcb_subsystem.sv
tcb_subsystem_tb.sv

/* Makefile */
# Verilator build and run of the subsystem testbench

TOP := tcb_subsystem_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/100ps -f tb.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

/* tcb_subsystem_tb.sv */
/*
  testbench for the bus subsystem
  - stimulus table applied in a loop, side table for stall relief
  - SRAM mirror and FIFO queue model for expected read data
  - LFSR write data and idle gaps, value check task, cycle watchdog
*/
`timescale 1ns/100ps
`default_nettype none

module tcb_subsystem_tb;

  import tcb_pkg::*;

  // one table row
  typedef struct packed {
    logic               wen;
    logic [TCB_ABW-1:0] adr;
    logic               rnd;    // write data from the LFSR
    logic [TCB_DBW-1:0] wdt;
    logic               sts;    // expected error status
    logic [1:0]         stall;  // cycles rdy must stay low first
    logic               b2b;    // no idle gap before this row
  } entry_t;

  localparam int WR = 1;
  localparam int RD = 0;

  logic               sub;
  logic               rst_n;
  logic               man_vld;
  logic               man_wen;
  logic [TCB_ABW-1:0] man_adr;
  logic [TCB_DBW-1:0] man_wdt;
  logic               man_rdy;
  logic [TCB_DBW-1:0] man_rdt;
  tcb_rsp_sts_t       man_sts;

  entry_t             main_tbl [$];
  entry_t             side_tbl [$];
  int                 side_idx;
  // reference model
  logic [TCB_DBW-1:0] sram_mdl [256];
  logic [TCB_DBW-1:0] fifo_mdl [$];
  logic [31:0]        lfsr;
  // response due in the cycle after its transfer
  logic               pend;
  logic               pend_rd;
  logic               pend_sts;
  logic [TCB_DBW-1:0] pend_rdt;
  int                 cycles = 0;
  int                 limit = 0;

  tcb_subsystem u_dut (
    .sub     (sub),
    .rst_n   (rst_n),
    .man_vld (man_vld),
    .man_wen (man_wen),
    .man_adr (man_adr),
    .man_wdt (man_wdt),
    .man_rdy (man_rdy),
    .man_rdt (man_rdt),
    .man_sts (man_sts)
  );

  initial begin
    sub = 1'b0;
    forever #4 sub = ~sub;
  end

  // watchdog
  always @(posedge sub) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("run timed out waiting for ready after %0d cycles", cycles);
      $display("CHECKS FAILED");
      $fatal(1, "timeout");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // fibonacci, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one step per bit
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic entry_t ent(input int wen, input logic [TCB_ABW-1:0] adr, input int rnd,
                                 input logic [TCB_DBW-1:0] wdt, input int sts,
                                 input int stall, input int b2b);
    return '{1'(wen), adr, 1'(rnd), wdt, 1'(sts), 2'(stall), 1'(b2b)};
  endfunction

  task automatic drive(input logic vld, input logic wen, input logic [TCB_ABW-1:0] adr,
                       input logic [TCB_DBW-1:0] wdt);
    man_vld = vld;
    man_wen = wen;
    man_adr = adr;
    man_wdt = wdt;
  endtask

  // one falling edge
  task automatic next_cycle();
    @(negedge sub);
  endtask

  // owed response, looked at once the next request is on the bus
  task automatic check_rsp();
    if (pend) begin
      if (pend_rd) begin
        check("man_rdt", man_rdt, pend_rdt);
      end
      check("man_sts", 32'(man_sts.err), 32'(pend_sts));
      pend = 1'b0;
    end
  endtask

  // starts on a falling edge, returns on the one after the transfer
  task automatic transfer(input entry_t e, input logic [TCB_DBW-1:0] wdt);
    drive(1'b1, e.wen, e.adr, wdt);
    #1;
    check_rsp();
    // hold the request until accepted
    while (!man_rdy) begin
      @(negedge sub);
      #1;
    end
    pend     = 1'b1;
    pend_rd  = !e.wen;
    pend_sts = e.sts;
    pend_rdt = '0;
    // SRAM 0x000..0x0ff, FIFO at 0x100, rest reads as 0
    if (e.adr <= 12'h0ff) begin
      if (e.wen) begin
        sram_mdl[e.adr[7:0]] = wdt;
      end else begin
        pend_rdt = sram_mdl[e.adr[7:0]];
      end
    end else if (e.adr == 12'h100) begin
      if (e.wen) begin
        fifo_mdl.push_back(wdt);
      end else if (fifo_mdl.size() == 0) begin
        $display("FIFO model is empty on a read at %0t, table order is wrong", $time);
        $display("CHECKS FAILED");
        $fatal(1, "model underflow");
      end else begin
        pend_rdt = fifo_mdl.pop_front();
      end
    end
    next_cycle();
  endtask

  task automatic apply(input entry_t e);
    logic [31:0] gap;
    logic [31:0] wdt;
    gap = '0;
    if (!e.b2b) begin
      take_bits(2, gap);
    end
    wdt = e.wdt;
    if (e.rnd) begin
      take_bits(32, wdt);
    end
    repeat (gap) begin
      drive(1'b0, 1'b0, 12'h000, 32'h0);
      #1;
      check_rsp();
      next_cycle();
    end
    if (e.stall != 0) begin
      // request shown without vld, rdy must stay low
      drive(1'b0, e.wen, e.adr, wdt);
      repeat (e.stall) begin
        #1;
        check_rsp();
        check("man_rdy", 32'(man_rdy), 32'd0);
        next_cycle();
      end
      // side row frees the FIFO
      transfer(side_tbl[side_idx], side_tbl[side_idx].wdt);
      side_idx++;
    end
    transfer(e, wdt);
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////////////////////////

  task automatic fill_tables();
    // SRAM write then read back
    main_tbl.push_back(ent(WR, 12'h000, 1, 32'h0, 0, 0, 0));
    main_tbl.push_back(ent(WR, 12'h005, 1, 32'h0, 0, 0, 0));
    main_tbl.push_back(ent(WR, 12'h0a3, 1, 32'h0, 0, 0, 0));
    main_tbl.push_back(ent(WR, 12'h0ff, 1, 32'h0, 0, 0, 0));
    main_tbl.push_back(ent(RD, 12'h0ff, 0, 32'h0, 0, 0, 0));
    main_tbl.push_back(ent(RD, 12'h000, 0, 32'h0, 0, 0, 0));
    main_tbl.push_back(ent(RD, 12'h0a3, 0, 32'h0, 0, 0, 0));
    main_tbl.push_back(ent(RD, 12'h005, 0, 32'h0, 0, 0, 0));
    // FIFO order
    main_tbl.push_back(ent(WR, 12'h100, 0, 32'h1111_2222, 0, 0, 0));
    main_tbl.push_back(ent(WR, 12'h100, 1, 32'h0, 0, 0, 0));
    main_tbl.push_back(ent(RD, 12'h100, 0, 32'h0, 0, 0, 0));
    main_tbl.push_back(ent(RD, 12'h100, 0, 32'h0, 0, 0, 0));
    // fill, fifth write stalls until a side read
    main_tbl.push_back(ent(WR, 12'h100, 1, 32'h0, 0, 0, 0));
    main_tbl.push_back(ent(WR, 12'h100, 1, 32'h0, 0, 0, 0));
    main_tbl.push_back(ent(WR, 12'h100, 1, 32'h0, 0, 0, 0));
    main_tbl.push_back(ent(WR, 12'h100, 1, 32'h0, 0, 0, 0));
    main_tbl.push_back(ent(WR, 12'h100, 1, 32'h0, 0, 2, 0));
    main_tbl.push_back(ent(RD, 12'h100, 0, 32'h0, 0, 0, 0));
    main_tbl.push_back(ent(RD, 12'h100, 0, 32'h0, 0, 0, 0));
    main_tbl.push_back(ent(RD, 12'h100, 0, 32'h0, 0, 0, 0));
    main_tbl.push_back(ent(RD, 12'h100, 0, 32'h0, 0, 0, 0));
    // empty read stalls until a side write
    main_tbl.push_back(ent(RD, 12'h100, 0, 32'h0, 0, 2, 0));
    // unmapped, 0x105 aliases SRAM word 0x005 in the low bits
    main_tbl.push_back(ent(WR, 12'h105, 0, 32'hdead_beef, 1, 0, 0));
    main_tbl.push_back(ent(RD, 12'h7ff, 0, 32'h0, 1, 0, 0));
    main_tbl.push_back(ent(RD, 12'hfff, 0, 32'h0, 1, 0, 0));
    main_tbl.push_back(ent(RD, 12'h005, 0, 32'h0, 0, 0, 0));
    main_tbl.push_back(ent(WR, 12'h100, 1, 32'h0, 0, 0, 0));
    main_tbl.push_back(ent(WR, 12'h180, 0, 32'h5a5a_a5a5, 1, 0, 0));
    main_tbl.push_back(ent(RD, 12'h100, 0, 32'h0, 0, 0, 0));
    // back to back across all ports
    main_tbl.push_back(ent(WR, 12'h010, 1, 32'h0, 0, 0, 1));
    main_tbl.push_back(ent(WR, 12'h100, 1, 32'h0, 0, 0, 1));
    main_tbl.push_back(ent(RD, 12'h200, 0, 32'h0, 1, 0, 1));
    main_tbl.push_back(ent(RD, 12'h010, 0, 32'h0, 0, 0, 1));
    main_tbl.push_back(ent(RD, 12'h100, 0, 32'h0, 0, 0, 1));
    main_tbl.push_back(ent(RD, 12'h123, 0, 32'h0, 1, 0, 1));
    main_tbl.push_back(ent(RD, 12'h0a3, 0, 32'h0, 0, 0, 1));
    // stall relief, used in order
    side_tbl.push_back(ent(RD, 12'h100, 0, 32'h0, 0, 0, 1));
    side_tbl.push_back(ent(WR, 12'h100, 0, 32'hcafe_0001, 0, 0, 1));
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    lfsr     = 32'h9b0a_6ca7;
    side_idx = 0;
    pend     = 1'b0;
    pend_rd  = 1'b0;
    pend_sts = 1'b0;
    pend_rdt = '0;
    rst_n    = 1'b0;
    drive(1'b0, 1'b0, 12'h000, 32'h0);
    fill_tables();
    limit = (main_tbl.size() + side_tbl.size()) * 8 + 20;
    repeat (10) @(posedge sub);
    @(negedge sub);
    rst_n = 1'b1;
    // response registers cleared by reset
    check("man_sts", 32'(man_sts.err), 32'd0);
    check("man_rdt", man_rdt, 32'h0);
    foreach (main_tbl[i]) begin
      apply(main_tbl[i]);
    end
    drive(1'b0, 1'b0, 12'h000, 32'h0);
    #1;
    check_rsp();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule: tcb_subsystem_tb

`default_nettype wire

/* tcb_subsystem.sv */
/*
  bus subsystem top level
  - address decoder with error responder
  - demultiplexer to SRAM, FIFO and error ports
*/
`timescale 1ns/100ps
`default_nettype none

module tcb_subsystem (
  input  logic                            sub,
  input  logic                            rst_n,
  // external manager port
  input  logic                            man_vld,
  input  logic                            man_wen,
  input  logic [tcb_pkg::TCB_ABW-1:0]     man_adr,
  input  logic [tcb_pkg::TCB_DBW-1:0]     man_wdt,
  output logic                            man_rdy,
  output logic [tcb_pkg::TCB_DBW-1:0]     man_rdt,
  output tcb_pkg::tcb_rsp_sts_t           man_sts
);

  import tcb_pkg::*;

  // port select from the decoder
  logic [TCB_MPL-1:0]                sel;

  // demultiplexer manager side
  logic [TCB_MPN-1:0]                dmx_vld;
  logic                              dmx_wen;
  logic [TCB_ABW-1:0]                dmx_adr;
  logic [TCB_DBW-1:0]                dmx_wdt;
  logic [TCB_MPN-1:0]                dmx_rdy;
  logic [TCB_MPN-1:0][TCB_DBW-1:0]   dmx_rdt;
  tcb_rsp_sts_t [TCB_MPN-1:0]        dmx_sts;

  //////////////////////////////////////////////////////////////////////
  // decode and routing
  //////////////////////////////////////////////////////////////////////

  // error responder sits on PORT_ERR
  tcb_map_decoder u_dec (
    .sub   (sub),
    .rst_n (rst_n),
    .adr   (man_adr),
    .sel   (sel),
    .vld   (dmx_vld[PORT_ERR]),
    .rdy   (dmx_rdy[PORT_ERR]),
    .rdt   (dmx_rdt[PORT_ERR]),
    .sts   (dmx_sts[PORT_ERR])
  );

  tcb_lib_demultiplexer #(
    .MPN (TCB_MPN)
  ) u_dmx (
    .sub     (sub),
    .rst_n   (rst_n),
    .sel     (sel),
    .sub_vld (man_vld),
    .sub_wen (man_wen),
    .sub_adr (man_adr),
    .sub_wdt (man_wdt),
    .sub_rdy (man_rdy),
    .sub_rdt (man_rdt),
    .sub_sts (man_sts),
    .man_vld (dmx_vld),
    .man_wen (dmx_wen),
    .man_adr (dmx_adr),
    .man_wdt (dmx_wdt),
    .man_rdy (dmx_rdy),
    .man_rdt (dmx_rdt),
    .man_sts (dmx_sts)
  );

  //////////////////////////////////////////////////////////////////////
  // subordinates
  //////////////////////////////////////////////////////////////////////

  tcb_sram u_sram (
    .sub   (sub),
    .rst_n (rst_n),
    .vld   (dmx_vld[PORT_SRAM]),
    .wen   (dmx_wen),
    .adr   (dmx_adr),
    .wdt   (dmx_wdt),
    .rdy   (dmx_rdy[PORT_SRAM]),
    .rdt   (dmx_rdt[PORT_SRAM]),
    .sts   (dmx_sts[PORT_SRAM])
  );

  // single word, no address
  tcb_fifo_port u_fifo (
    .sub   (sub),
    .rst_n (rst_n),
    .vld   (dmx_vld[PORT_FIFO]),
    .wen   (dmx_wen),
    .wdt   (dmx_wdt),
    .rdy   (dmx_rdy[PORT_FIFO]),
    .rdt   (dmx_rdt[PORT_FIFO]),
    .sts   (dmx_sts[PORT_FIFO])
  );

endmodule: tcb_subsystem

`default_nettype wire

/* tcb_fifo_port.sv */
/*
  FIFO peripheral subordinate
  - circular buffer of FIFO_DEPTH words
  - write pushes, read pops with data one cycle later
  - stalls writes when full and reads when empty
*/
`timescale 1ns/100ps
`default_nettype none

module tcb_fifo_port (
  input  logic                            sub,
  input  logic                            rst_n,
  // request, the port is a single word so no address
  input  logic                            vld,
  input  logic                            wen,
  input  logic [tcb_pkg::TCB_DBW-1:0]     wdt,
  // handshake and response
  output logic                            rdy,
  output logic [tcb_pkg::TCB_DBW-1:0]     rdt,
  output tcb_pkg::tcb_rsp_sts_t           sts
);

  import tcb_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // storage and state
  //////////////////////////////////////////////////////////////////////

  logic [TCB_DBW-1:0]    mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  // fill count, 0..FIFO_DEPTH
  logic [FIFO_CNT_W-1:0] cnt;

  logic full;
  logic empty;
  logic push;
  logic pop;

  assign full  = (cnt == FIFO_CNT_W'(FIFO_DEPTH));
  assign empty = (cnt == '0);

  // ready depends on the direction of the pending access
  assign rdy = wen ? !full : !empty;

  assign push = vld & rdy & wen;
  assign pop  = vld & rdy & !wen;

  // access never fails, only stalls
  assign sts = '0;

  //////////////////////////////////////////////////////////////////////
  // pointers and count
  //////////////////////////////////////////////////////////////////////

  // push and pop are exclusive, one transfer per cycle
  always_ff @(posedge sub) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + FIFO_PTR_W'(1);
        cnt    <= cnt + FIFO_CNT_W'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + FIFO_PTR_W'(1);
        cnt    <= cnt - FIFO_CNT_W'(1);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // data
  //////////////////////////////////////////////////////////////////////

  // pointers wrap naturally, depth is a power of two
  always_ff @(posedge sub) begin
    if (push) begin
      mem[wr_ptr] <= wdt;
    end
  end

  // oldest word out on a pop
  // cleared at reset, held until the next pop
  always_ff @(posedge sub) begin
    if (!rst_n) begin
      rdt <= '0;
    end else if (pop) begin
      rdt <= mem[rd_ptr];
    end
  end

endmodule: tcb_fifo_port

`default_nettype wire

/* tcb_sram.sv */
/*
  word SRAM subordinate
  - SRAM_WORDS words, always ready
  - write on transfer, registered read data one cycle later
*/
`timescale 1ns/100ps
`default_nettype none

module tcb_sram (
  input  logic                            sub,
  input  logic                            rst_n,
  // request
  input  logic                            vld,
  input  logic                            wen,
  input  logic [tcb_pkg::TCB_ABW-1:0]     adr,
  input  logic [tcb_pkg::TCB_DBW-1:0]     wdt,
  // handshake and response
  output logic                            rdy,
  output logic [tcb_pkg::TCB_DBW-1:0]     rdt,
  output tcb_pkg::tcb_rsp_sts_t           sts
);

  import tcb_pkg::*;

  logic [TCB_DBW-1:0] mem [SRAM_WORDS];
  // word offset inside the window
  logic [TCB_ABW-1:0] ofs;
  logic [SRAM_AW-1:0] idx;

  assign ofs = adr - SRAM_BASE;
  assign idx = ofs[SRAM_AW-1:0];

  // no wait states, no errors
  assign rdy = 1'b1;
  assign sts = '0;

  // array write
  always_ff @(posedge sub) begin
    if (vld && wen) begin
      mem[idx] <= wdt;
    end
  end

  // read data register, held between reads
  always_ff @(posedge sub) begin
    if (!rst_n) begin
      rdt <= '0;
    end else if (vld && !wen) begin
      rdt <= mem[idx];
    end
  end

endmodule: tcb_sram

`default_nettype wire

/* tcb_lib_demultiplexer.sv */
/*
  bus demultiplexer, one subordinate port to MPN manager ports
  - request routed combinationally from the current select
  - select latched per transfer to steer the response
*/
`timescale 1ns/100ps
`default_nettype none

module tcb_lib_demultiplexer #(
  parameter int unsigned MPN = tcb_pkg::TCB_MPN
)(
  input  logic                                      sub,
  input  logic                                      rst_n,
  // port select for the current request
  input  logic [tcb_pkg::TCB_MPL-1:0]               sel,
  // subordinate side, the external manager connects here
  input  logic                                      sub_vld,
  input  logic                                      sub_wen,
  input  logic [tcb_pkg::TCB_ABW-1:0]               sub_adr,
  input  logic [tcb_pkg::TCB_DBW-1:0]               sub_wdt,
  output logic                                      sub_rdy,
  output logic [tcb_pkg::TCB_DBW-1:0]               sub_rdt,
  output tcb_pkg::tcb_rsp_sts_t                     sub_sts,
  // manager side, subordinates connect here
  output logic [MPN-1:0]                            man_vld,
  output logic                                      man_wen,
  output logic [tcb_pkg::TCB_ABW-1:0]               man_adr,
  output logic [tcb_pkg::TCB_DBW-1:0]               man_wdt,
  input  logic [MPN-1:0]                            man_rdy,
  input  logic [MPN-1:0][tcb_pkg::TCB_DBW-1:0]      man_rdt,
  input  tcb_pkg::tcb_rsp_sts_t [MPN-1:0]           man_sts
);

  import tcb_pkg::*;

  // select of the transfer whose response is due
  logic [TCB_MPL-1:0] rsp_sel;
  logic               trn;

  //////////////////////////////////////////////////////////////////////
  // request
  //////////////////////////////////////////////////////////////////////

  // only the selected port sees vld
  for (genvar i = 0; i < MPN; i++) begin: gen_vld
    assign man_vld[i] = sub_vld & (sel == TCB_MPL'(i));
  end: gen_vld

  // fields go to every port
  assign man_wen = sub_wen;
  assign man_adr = sub_adr;
  assign man_wdt = sub_wdt;

  // handshake back from the selected port
  // out of range select never becomes ready
  assign sub_rdy = (32'(sel) < MPN) ? man_rdy[sel] : 1'b0;

  assign trn = sub_vld & sub_rdy;

  //////////////////////////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////////////////////////

  // follows the request select one cycle late
  always_ff @(posedge sub) begin
    if (!rst_n) begin
      rsp_sel <= '0;
    end else if (trn) begin
      rsp_sel <= sel;
    end
  end

  // response from the port of the previous transfer,
  // while a new request may already target another port
  assign sub_rdt = man_rdt[rsp_sel];
  assign sub_sts = man_sts[rsp_sel];

endmodule: tcb_lib_demultiplexer

`default_nettype wire

/* tcb_map_decoder.sv */
/*
  address decoder for the subsystem memory map
  - combinational port select from the word address
  - error responder subordinate for unmapped addresses
*/
`timescale 1ns/100ps
`default_nettype none

module tcb_map_decoder (
  input  logic                            sub,
  input  logic                            rst_n,
  // address in, select out
  input  logic [tcb_pkg::TCB_ABW-1:0]     adr,
  output logic [tcb_pkg::TCB_MPL-1:0]     sel,
  // error port handshake and response
  input  logic                            vld,
  output logic                            rdy,
  output logic [tcb_pkg::TCB_DBW-1:0]     rdt,
  output tcb_pkg::tcb_rsp_sts_t           sts
);

  import tcb_pkg::*;

  // offset into the SRAM window, wraps below the base
  logic [TCB_ABW-1:0] sram_ofs;
  logic               hit_sram;
  logic               hit_fifo;

  //////////////////////////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////////////////////////

  assign sram_ofs = adr - SRAM_BASE;
  assign hit_sram = (sram_ofs < TCB_ABW'(SRAM_WORDS));
  assign hit_fifo = (adr == FIFO_ADR);

  // SRAM has priority, anything else falls to the error port
  always_comb begin
    if (hit_sram) begin
      sel = PORT_SRAM;
    end else if (hit_fifo) begin
      sel = PORT_FIFO;
    end else begin
      sel = PORT_ERR;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // error responder
  //////////////////////////////////////////////////////////////////////

  // never stalls
  assign rdy = 1'b1;
  // no data on an error
  assign rdt = '0;

  // rdy is constant, so vld alone marks a transfer
  always_ff @(posedge sub) begin
    if (!rst_n) begin
      sts <= '0;
    end else begin
      sts.err <= vld;
    end
  end

endmodule: tcb_map_decoder

`default_nettype wire

/* tcb_pkg.sv */
/*
  shared definitions for the tightly coupled bus subsystem
  - bus widths and demultiplexer port count
  - response status type
  - memory map and subordinate port select values
  - FIFO peripheral sizing
*/
`default_nettype none

package tcb_pkg;

  //////////////////////////////////////////////////////////////////////
  // bus geometry
  //////////////////////////////////////////////////////////////////////

  // word address width
  localparam int unsigned TCB_ABW = 12;
  // data width
  localparam int unsigned TCB_DBW = 32;
  // manager ports on the demultiplexer, and select width
  localparam int unsigned TCB_MPN = 3;
  localparam int unsigned TCB_MPL = 2;

  // response status, err set for unmapped address or bad access
  typedef struct packed {
    logic err;
  } tcb_rsp_sts_t;

  //////////////////////////////////////////////////////////////////////
  // memory map
  //////////////////////////////////////////////////////////////////////

  // SRAM window 0x000..0x0ff
  localparam logic [TCB_ABW-1:0] SRAM_BASE  = 12'h000;
  localparam int unsigned        SRAM_WORDS = 256;
  localparam int unsigned        SRAM_AW    = $clog2(SRAM_WORDS);
  // FIFO is a single word
  localparam logic [TCB_ABW-1:0] FIFO_ADR   = 12'h100;

  // FIFO sizing, count needs one bit more than the pointers
  localparam int unsigned FIFO_DEPTH = 4;
  localparam int unsigned FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int unsigned FIFO_CNT_W = 3;

  // port select values
  localparam logic [TCB_MPL-1:0] PORT_SRAM = 2'd0;
  localparam logic [TCB_MPL-1:0] PORT_FIFO = 2'd1;
  localparam logic [TCB_MPL-1:0] PORT_ERR  = 2'd2;

endpackage: tcb_pkg

`default_nettype wire
